// File: design/ita_dp_pkg.sv
// Datapath sizes and element types
// Input chunk, weight tile, bias, accumulator and output beat
package ita_dp_pkg;

  // Elements per input chunk and per weight-tile row
  localparam int unsigned N = 4;
  // Output channels
  localparam int unsigned M = 4;
  // Element width
  localparam int unsigned WI = 8;
  // Bias width
  localparam int unsigned WB = 16;
  // Accumulator width
  localparam int unsigned AccW = 24;
  // Sum of N products before accumulation
  localparam int unsigned SumW = 2 * WI + $clog2(N);

  typedef logic signed [WI-1:0] elem_t;
  typedef logic signed [WB-1:0] bias_elem_t;
  typedef logic signed [SumW-1:0] sum_t;
  typedef logic signed [AccW-1:0] acc_t;

  // One input chunk
  typedef elem_t [N-1:0] inp_t;

  // Row m holds the weights of channel m
  typedef inp_t [M-1:0] weight_t;

  typedef bias_elem_t [M-1:0] bias_t;

  typedef acc_t [M-1:0] acc_vec_t;

  // Output beat, also the FIFO payload
  typedef elem_t [M-1:0] oup_t;

endpackage

// File: design/ita_ctrl_pkg.sv
// Job configuration, requantization fields, counter types and limits
// Controller phases
package ita_ctrl_pkg;

  // Maximum number of inner tiles
  localparam int unsigned KMax = 4;
  // Output FIFO depth
  localparam int unsigned FifoDepth = 4;

  typedef logic [7:0] eps_mult_t;
  typedef logic [4:0] right_shift_t;
  typedef logic signed [7:0] add_t;

  // Holds K-1 and the tile index
  typedef logic [$clog2(KMax)-1:0] tile_cnt_t;
  // Holds R-1
  typedef logic [7:0] row_cnt_t;
  // Rows in flight or waiting in the FIFO
  typedef logic [$clog2(FifoDepth+1)-1:0] credit_cnt_t;

  typedef struct packed {
    tile_cnt_t    tiles_m1;
    row_cnt_t     rows_m1;
    eps_mult_t    eps_mult;
    right_shift_t right_shift;
    add_t         add;
    logic         relu_en;
  } ctrl_t;

  typedef enum logic [1:0] {
    Idle,
    Bias,
    Load,
    Compute
  } step_e;

endpackage

// File: design/ita_cfg_regs.sv
// Job configuration register
`timescale 1ns/1ps
`default_nettype none

module ita_cfg_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic                 busy_i,
  input  ita_ctrl_pkg::ctrl_t  ctrl_i,
  output ita_ctrl_pkg::ctrl_t  cfg_o
);

  ita_ctrl_pkg::ctrl_t cfg_q;
  logic                load;

  // A start while busy is ignored by the controller as well
  assign load = start_i && !busy_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (load) begin
      cfg_q <= ctrl_i;
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: design/ita_controller.sv
// Job sequencing FSM with tile, row and output credit counters
`timescale 1ns/1ps
`default_nettype none

module ita_controller (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  ita_ctrl_pkg::ctrl_t       cfg_i,
  input  logic                      inp_valid_i,
  output logic                      inp_ready_o,
  input  logic                      weight_valid_i,
  output logic                      weight_ready_o,
  input  logic                      bias_valid_i,
  output logic                      bias_ready_o,
  input  logic                      pop_i,
  output logic                      busy_o,
  output logic                      bias_we_o,
  output logic                      weight_we_o,
  output ita_ctrl_pkg::tile_cnt_t   tile_idx_o,
  output logic                      calc_en_o,
  output logic                      first_tile_o,
  output logic                      last_tile_o
);

  import ita_ctrl_pkg::*;

  step_e       step_q, step_d;
  tile_cnt_t   tile_q, tile_d;
  row_cnt_t    row_q, row_d;
  credit_cnt_t credit_q, credit_d;
  logic        rows_done_q, rows_done_d;
  logic        inp_hs, weight_hs, bias_hs;
  logic        row_start, last_tile;
  logic        calc_en_q, first_tile_q, last_tile_q;

  assign bias_ready_o   = (step_q == Bias);
  assign weight_ready_o = (step_q == Load);
  // A new row needs a free FIFO slot, chunks of a started row always pass
  assign inp_ready_o    = (step_q == Compute) && !rows_done_q &&
                          ((tile_q != '0) || (credit_q < FifoDepth));

  assign inp_hs    = inp_valid_i && inp_ready_o;
  assign weight_hs = weight_valid_i && weight_ready_o;
  assign bias_hs   = bias_valid_i && bias_ready_o;

  assign last_tile = (tile_q == cfg_i.tiles_m1);
  assign row_start = inp_hs && (tile_q == '0);

  always_comb begin
    credit_d = credit_q;
    if (row_start && !pop_i) begin
      credit_d = credit_q + 1'b1;
    end else if (!row_start && pop_i) begin
      credit_d = credit_q - 1'b1;
    end
  end

  always_comb begin
    step_d      = step_q;
    tile_d      = tile_q;
    row_d       = row_q;
    rows_done_d = rows_done_q;
    unique case (step_q)
      Idle: begin
        if (start_i) begin
          step_d      = Bias;
          tile_d      = '0;
          row_d       = '0;
          rows_done_d = 1'b0;
        end
      end
      Bias: begin
        if (bias_hs) step_d = Load;
      end
      Load: begin
        if (weight_hs) begin
          if (last_tile) begin
            step_d = Compute;
            tile_d = '0;
          end else begin
            tile_d = tile_q + 1'b1;
          end
        end
      end
      Compute: begin
        if (inp_hs) begin
          if (last_tile) begin
            tile_d = '0;
            if (row_q == cfg_i.rows_m1) rows_done_d = 1'b1;
            else row_d = row_q + 1'b1;
          end else begin
            tile_d = tile_q + 1'b1;
          end
        end
        // Job ends once every row has left the FIFO
        if (rows_done_d && (credit_d == '0)) step_d = Idle;
      end
      default: step_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      step_q       <= Idle;
      tile_q       <= '0;
      row_q        <= '0;
      credit_q     <= '0;
      rows_done_q  <= 1'b0;
      calc_en_q    <= 1'b0;
      first_tile_q <= 1'b0;
      last_tile_q  <= 1'b0;
    end else begin
      step_q       <= step_d;
      tile_q       <= tile_d;
      row_q        <= row_d;
      credit_q     <= credit_d;
      rows_done_q  <= rows_done_d;
      // Aligned with the registered weight read and input sample
      calc_en_q    <= inp_hs;
      first_tile_q <= inp_hs && (tile_q == '0);
      last_tile_q  <= inp_hs && last_tile;
    end
  end

  assign busy_o       = (step_q != Idle);
  assign bias_we_o    = bias_hs;
  assign weight_we_o  = weight_hs;
  assign tile_idx_o   = tile_q;
  assign calc_en_o    = calc_en_q;
  assign first_tile_o = first_tile_q;
  assign last_tile_o  = last_tile_q;

endmodule

`default_nettype wire

// File: design/ita_weight_buffer.sv
// Weight tile storage and bias register
// Tile read is registered
`timescale 1ns/1ps
`default_nettype none

module ita_weight_buffer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      bias_we_i,
  input  ita_dp_pkg::bias_t         bias_i,
  input  logic                      weight_we_i,
  input  ita_ctrl_pkg::tile_cnt_t   tile_idx_i,
  input  ita_dp_pkg::weight_t       weight_i,
  input  logic                      read_en_i,
  output ita_dp_pkg::weight_t       weight_o,
  output ita_dp_pkg::bias_t         bias_o
);

  import ita_dp_pkg::*;
  import ita_ctrl_pkg::*;

  weight_t tiles_q [KMax];
  weight_t rdata_q;
  bias_t   bias_q;

  always_ff @(posedge clk_i) begin
    if (weight_we_i) begin
      tiles_q[tile_idx_i] <= weight_i;
    end
    if (bias_we_i) begin
      bias_q <= bias_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (read_en_i) begin
      rdata_q <= tiles_q[tile_idx_i];
    end
  end

  assign weight_o = rdata_q;
  assign bias_o   = bias_q;

endmodule

`default_nettype wire

// File: design/ita_dotp_acc.sv
// M parallel dot products with accumulation over inner tiles
`timescale 1ns/1ps
`default_nettype none

module ita_dotp_acc (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  calc_en_i,
  input  logic                  first_tile_i,
  input  logic                  last_tile_i,
  input  ita_dp_pkg::inp_t      inp_i,
  input  ita_dp_pkg::weight_t   weight_i,
  input  ita_dp_pkg::bias_t     bias_i,
  output ita_dp_pkg::acc_vec_t  result_o,
  output logic                  result_valid_o
);

  import ita_dp_pkg::*;

  sum_t     sum_d [M];
  sum_t     sum_q [M];
  logic     calc_en_q, first_q, last_q;
  acc_vec_t acc_q;
  logic     result_valid_q;

  always_comb begin
    for (int m = 0; m < M; m++) begin
      sum_d[m] = '0;
      for (int n = 0; n < N; n++) begin
        sum_d[m] = sum_d[m] + $signed(inp_i[n]) * $signed(weight_i[m][n]);
      end
    end
  end

  // Stage one: products
  always_ff @(posedge clk_i) begin
    if (calc_en_i) begin
      sum_q <= sum_d;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      calc_en_q      <= 1'b0;
      first_q        <= 1'b0;
      last_q         <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      calc_en_q      <= calc_en_i;
      first_q        <= first_tile_i;
      last_q         <= last_tile_i;
      result_valid_q <= calc_en_q && last_q;
    end
  end

  // Stage two: bias is loaded with the first tile
  always_ff @(posedge clk_i) begin
    if (calc_en_q) begin
      for (int m = 0; m < M; m++) begin
        if (first_q) acc_q[m] <= acc_t'($signed(bias_i[m])) + acc_t'(sum_q[m]);
        else acc_q[m] <= acc_q[m] + acc_t'(sum_q[m]);
      end
    end
  end

  assign result_o       = acc_q;
  assign result_valid_o = result_valid_q;

endmodule

`default_nettype wire

// File: design/ita_requant_act.sv
// Requantization, saturation and optional ReLU of one row result
`timescale 1ns/1ps
`default_nettype none

module ita_requant_act (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       valid_i,
  input  ita_dp_pkg::acc_vec_t       result_i,
  input  ita_ctrl_pkg::eps_mult_t    eps_mult_i,
  input  ita_ctrl_pkg::right_shift_t right_shift_i,
  input  ita_ctrl_pkg::add_t         add_i,
  input  logic                       relu_en_i,
  output ita_dp_pkg::oup_t           oup_o,
  output logic                       valid_o
);

  import ita_dp_pkg::*;

  // Signed product of accumulator and unsigned multiplier
  localparam int unsigned ProdW = AccW + 9;

  oup_t oup_d, oup_q;
  logic valid_q;

  function automatic elem_t requant_lane(input acc_t acc);
    logic signed [ProdW-1:0] prod;
    logic signed [ProdW:0]   val;
    elem_t                   res;
    prod = acc * $signed({1'b0, eps_mult_i});
    // Arithmetic shift rounds toward minus infinity
    val  = (prod >>> right_shift_i) + add_i;
    if (val > 127) res = 8'sd127;
    else if (val < -128) res = -8'sd128;
    else res = elem_t'(val);
    if (relu_en_i && res < 0) res = '0;
    return res;
  endfunction

  always_comb begin
    for (int m = 0; m < M; m++) begin
      oup_d[m] = requant_lane(result_i[m]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      oup_q <= oup_d;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  assign oup_o   = oup_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

// File: design/ita_fifo.sv
// Synchronous FIFO, payload given by a type parameter
`timescale 1ns/1ps
`default_nettype none

module ita_fifo #(
  parameter type         data_t = logic,
  parameter int unsigned Depth  = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  data_t data_i,
  output logic  full_o,
  input  logic  pop_i,
  output data_t data_o,
  output logic  empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [PtrW-1:0]              ptr_t;
  typedef logic [$clog2(Depth+1)-1:0]   cnt_t;

  data_t mem_q [Depth];
  ptr_t  wptr_q, rptr_q;
  cnt_t  cnt_q;
  logic  do_push, do_pop;

  assign full_o  = (cnt_q == cnt_t'(Depth));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == ptr_t'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == ptr_t'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (do_push && !do_pop) cnt_q <= cnt_q + 1'b1;
      else if (!do_push && do_pop) cnt_q <= cnt_q - 1'b1;
    end
  end

  // Head entry straight from storage
  assign data_o = mem_q[rptr_q];

endmodule

`default_nettype wire

// File: design/ita.sv
// Matrix-vector engine top level
// Input sample register and block interconnect
`timescale 1ns/1ps
`default_nettype none

module ita (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  ita_ctrl_pkg::ctrl_t   ctrl_i,
  input  logic                  inp_valid_i,
  output logic                  inp_ready_o,
  input  ita_dp_pkg::inp_t      inp_i,
  input  logic                  inp_weight_valid_i,
  output logic                  inp_weight_ready_o,
  input  ita_dp_pkg::weight_t   inp_weight_i,
  input  logic                  inp_bias_valid_i,
  output logic                  inp_bias_ready_o,
  input  ita_dp_pkg::bias_t     inp_bias_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output ita_dp_pkg::oup_t      oup_o,
  output logic                  busy_o
);

  import ita_dp_pkg::*;
  import ita_ctrl_pkg::*;

  ctrl_t     cfg;
  tile_cnt_t tile_idx;
  logic      bias_we, weight_we;
  logic      calc_en, first_tile, last_tile;
  logic      inp_hs, pop;
  inp_t      inp_q;
  weight_t   weight_rd;
  bias_t     bias_rd;
  acc_vec_t  result;
  logic      result_valid;
  oup_t      requant_oup;
  logic      requant_valid;
  logic      fifo_full, fifo_empty;

  assign inp_hs = inp_valid_i && inp_ready_o;

  // Sampled alongside the weight read
  always_ff @(posedge clk_i) begin
    if (inp_hs) begin
      inp_q <= inp_i;
    end
  end

  assign valid_o = !fifo_empty;
  assign pop     = valid_o && ready_i;

  ita_cfg_regs i_cfg_regs (
    .clk_i  (clk_i  ),
    .rst_ni (rst_ni ),
    .start_i(start_i),
    .busy_i (busy_o ),
    .ctrl_i (ctrl_i ),
    .cfg_o  (cfg    )
  );

  ita_controller i_controller (
    .clk_i         (clk_i             ),
    .rst_ni        (rst_ni            ),
    .start_i       (start_i           ),
    .cfg_i         (cfg               ),
    .inp_valid_i   (inp_valid_i       ),
    .inp_ready_o   (inp_ready_o       ),
    .weight_valid_i(inp_weight_valid_i),
    .weight_ready_o(inp_weight_ready_o),
    .bias_valid_i  (inp_bias_valid_i  ),
    .bias_ready_o  (inp_bias_ready_o  ),
    .pop_i         (pop               ),
    .busy_o        (busy_o            ),
    .bias_we_o     (bias_we           ),
    .weight_we_o   (weight_we         ),
    .tile_idx_o    (tile_idx          ),
    .calc_en_o     (calc_en           ),
    .first_tile_o  (first_tile        ),
    .last_tile_o   (last_tile         )
  );

  ita_weight_buffer i_weight_buffer (
    .clk_i      (clk_i       ),
    .rst_ni     (rst_ni      ),
    .bias_we_i  (bias_we     ),
    .bias_i     (inp_bias_i  ),
    .weight_we_i(weight_we   ),
    .tile_idx_i (tile_idx    ),
    .weight_i   (inp_weight_i),
    .read_en_i  (inp_hs      ),
    .weight_o   (weight_rd   ),
    .bias_o     (bias_rd     )
  );

  ita_dotp_acc i_dotp_acc (
    .clk_i         (clk_i       ),
    .rst_ni        (rst_ni      ),
    .calc_en_i     (calc_en     ),
    .first_tile_i  (first_tile  ),
    .last_tile_i   (last_tile   ),
    .inp_i         (inp_q       ),
    .weight_i      (weight_rd   ),
    .bias_i        (bias_rd     ),
    .result_o      (result      ),
    .result_valid_o(result_valid)
  );

  ita_requant_act i_requant_act (
    .clk_i        (clk_i          ),
    .rst_ni       (rst_ni         ),
    .valid_i      (result_valid   ),
    .result_i     (result         ),
    .eps_mult_i   (cfg.eps_mult   ),
    .right_shift_i(cfg.right_shift),
    .add_i        (cfg.add        ),
    .relu_en_i    (cfg.relu_en    ),
    .oup_o        (requant_oup    ),
    .valid_o      (requant_valid  )
  );

  // Credits keep the FIFO from filling up, full only guards the write
  ita_fifo #(
    .data_t(oup_t    ),
    .Depth (FifoDepth)
  ) i_fifo (
    .clk_i  (clk_i                      ),
    .rst_ni (rst_ni                     ),
    .push_i (requant_valid && !fifo_full),
    .data_i (requant_oup                ),
    .full_o (fifo_full                  ),
    .pop_i  (pop                        ),
    .data_o (oup_o                      ),
    .empty_o(fifo_empty                 )
  );

endmodule

`default_nettype wire

// File: sim/ita_tb.sv
// Testbench for the matrix-vector engine
// Random jobs checked against a software model, with back-pressure and watchdog
`timescale 1ns/1ps
`default_nettype none

module ita_tb;

  import ita_dp_pkg::*;
  import ita_ctrl_pkg::*;

  localparam int NJobs      = 7;
  localparam int BeatCycles = 20;

  // Per job: tiles, rows, multiplier, shift, offset, ReLU, back-pressure
  int job_k     [NJobs] = '{1, 4, 4, 2, 3, 4, 1};
  int job_r     [NJobs] = '{6, 8, 5, 6, 6, 10, 20};
  int job_eps   [NJobs] = '{64, 50, 37, 255, 200, 90, 128};
  int job_shift [NJobs] = '{13, 14, 13, 2, 4, 15, 14};
  int job_add   [NJobs] = '{3, -5, 0, 0, 10, 7, 0};
  int job_relu  [NJobs] = '{0, 0, 0, 0, 1, 1, 0};
  int job_bp    [NJobs] = '{0, 0, 1, 0, 1, 1, 1};

  logic    clk_i;
  logic    rst_ni;
  logic    start_i;
  ctrl_t   ctrl_i;
  logic    inp_valid_i;
  logic    inp_ready_o;
  inp_t    inp_i;
  logic    inp_weight_valid_i;
  logic    inp_weight_ready_o;
  weight_t inp_weight_i;
  logic    inp_bias_valid_i;
  logic    inp_bias_ready_o;
  bias_t   inp_bias_i;
  logic    valid_o;
  logic    ready_i;
  oup_t    oup_o;
  logic    busy_o;

  // Model state of the running job
  ctrl_t   job_cfg;
  weight_t w_tiles [KMax];
  bias_t   bias;
  inp_t    chunk [KMax];
  oup_t    exp_q [$];
  string   test_name = "reset";

  int   errors       = 0;
  int   rows_checked = 0;
  int   sat_hi       = 0;
  int   sat_lo       = 0;
  int   relu_zero    = 0;
  int   relu_pos     = 0;
  int   stall_cnt    = 0;
  logic bp_en        = 1'b0;

  ita dut (
    .clk_i             (clk_i             ),
    .rst_ni            (rst_ni            ),
    .start_i           (start_i           ),
    .ctrl_i            (ctrl_i            ),
    .inp_valid_i       (inp_valid_i       ),
    .inp_ready_o       (inp_ready_o       ),
    .inp_i             (inp_i             ),
    .inp_weight_valid_i(inp_weight_valid_i),
    .inp_weight_ready_o(inp_weight_ready_o),
    .inp_weight_i      (inp_weight_i      ),
    .inp_bias_valid_i  (inp_bias_valid_i  ),
    .inp_bias_ready_o  (inp_bias_ready_o  ),
    .inp_bias_i        (inp_bias_i        ),
    .valid_o           (valid_o           ),
    .ready_i           (ready_i           ),
    .oup_o             (oup_o             ),
    .busy_o            (busy_o            )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Row result: dot products plus bias, then requant, saturation and ReLU
  function automatic oup_t model_row(input int k);
    oup_t   res;
    longint acc;
    longint val;
    for (int m = 0; m < M; m++) begin
      acc = longint'(bias[m]);
      for (int t = 0; t < k; t++) begin
        for (int n = 0; n < N; n++) begin
          acc += longint'(chunk[t][n]) * longint'(w_tiles[t][m][n]);
        end
      end
      val = (acc * longint'(job_cfg.eps_mult)) >>> job_cfg.right_shift;
      val += longint'($signed(job_cfg.add));
      if (val > 127) begin
        val = 127;
        sat_hi++;
      end else if (val < -128) begin
        val = -128;
        sat_lo++;
      end
      if (job_cfg.relu_en) begin
        if (val < 0) begin
          val = 0;
          relu_zero++;
        end else if (val > 0) begin
          relu_pos++;
        end
      end
      res[m] = elem_t'(val);
    end
    return res;
  endfunction

  // Port 0 is bias, 1 is weights, 2 is input chunks
  function automatic logic port_ready(input int port);
    case (port)
      0: return inp_bias_ready_o;
      1: return inp_weight_ready_o;
      default: return inp_ready_o;
    endcase
  endfunction

  task automatic drive_port(input int port, input logic v, input logic [127:0] data);
    case (port)
      0: begin
        inp_bias_valid_i = v;
        inp_bias_i       = data[63:0];
      end
      1: begin
        inp_weight_valid_i = v;
        inp_weight_i       = data;
      end
      default: begin
        inp_valid_i = v;
        inp_i       = data[31:0];
      end
    endcase
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_beat(input int port, input logic [127:0] data);
    int gap;
    gap = $urandom % 4;
    repeat (gap) @(negedge clk_i);
    drive_port(port, 1'b1, data);
    while (!port_ready(port)) @(negedge clk_i);
    @(negedge clk_i);
    drive_port(port, 1'b0, data);
  endtask

  task automatic run_job(input int j);
    int k;
    int r;
    k = job_k[j];
    r = job_r[j];
    test_name           = $sformatf("job%0d_k%0d_r%0d", j, k, r);
    job_cfg.tiles_m1    = tile_cnt_t'(k - 1);
    job_cfg.rows_m1     = row_cnt_t'(r - 1);
    job_cfg.eps_mult    = eps_mult_t'(job_eps[j]);
    job_cfg.right_shift = right_shift_t'(job_shift[j]);
    job_cfg.add         = add_t'(job_add[j]);
    job_cfg.relu_en     = (job_relu[j] != 0);
    bp_en               = (job_bp[j] != 0);

    ctrl_i  = job_cfg;
    start_i = 1'b1;
    @(negedge clk_i);
    // A second start with other settings while busy must be ignored
    ctrl_i  = ctrl_t'($urandom);
    assert (busy_o) else begin
      errors++;
      $display("Error in %s: busy_o did not rise after start", test_name);
    end
    @(negedge clk_i);
    start_i = 1'b0;

    for (int m = 0; m < M; m++) begin
      bias[m] = $signed(12'($urandom));
    end
    send_beat(0, {64'b0, bias});
    for (int t = 0; t < k; t++) begin
      for (int m = 0; m < M; m++) begin
        for (int n = 0; n < N; n++) begin
          w_tiles[t][m][n] = elem_t'($urandom);
        end
      end
      send_beat(1, w_tiles[t]);
    end

    for (int row = 0; row < r; row++) begin
      for (int t = 0; t < k; t++) begin
        for (int n = 0; n < N; n++) begin
          chunk[t][n] = elem_t'($urandom);
        end
      end
      exp_q.push_back(model_row(k));
      for (int t = 0; t < k; t++) begin
        send_beat(2, {96'b0, chunk[t]});
      end
    end

    while (busy_o) @(negedge clk_i);
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("Error in %s: busy_o fell with %0d rows not returned", test_name, exp_q.size());
    end
    assert (!valid_o) else begin
      errors++;
      $display("Error in %s: valid_o still high after the job ended", test_name);
    end
  endtask

  // Output side: random ready with long stalls, compares every popped beat
  initial begin
    oup_t exp_beat;
    forever begin
      @(negedge clk_i);
      if (!bp_en) begin
        ready_i = 1'b1;
      end else if (stall_cnt > 0) begin
        ready_i = 1'b0;
        stall_cnt--;
      end else if ($urandom % 40 == 0) begin
        stall_cnt = 20 + $urandom % 40;
        ready_i   = 1'b0;
      end else begin
        ready_i = ($urandom % 4 != 0);
      end
      if (rst_ni && valid_o && ready_i) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("Error in %s: output beat with no row pending", test_name);
        end
        if (exp_q.size() > 0) begin
          exp_beat = exp_q.pop_front();
          rows_checked++;
          assert (oup_o == exp_beat) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", test_name, exp_beat, oup_o);
          end
          assert (busy_o) else begin
            errors++;
            $display("Error in %s: busy_o low while a row was still queued", test_name);
          end
        end
      end
    end
  end

  // Limit from the beat count of all jobs
  initial begin
    int unsigned total;
    total = 0;
    for (int j = 0; j < NJobs; j++) begin
      total += 1 + job_k[j] + job_r[j] * job_k[j] + job_r[j];
    end
    repeat (total * BeatCycles + 10) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", total * BeatCycles + 10);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hf0d0b87a));
    rst_ni             = 1'b0;
    start_i            = 1'b0;
    ctrl_i             = '0;
    inp_valid_i        = 1'b0;
    inp_i              = '0;
    inp_weight_valid_i = 1'b0;
    inp_weight_i       = '0;
    inp_bias_valid_i   = 1'b0;
    inp_bias_i         = '0;
    ready_i            = 1'b0;

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert ({inp_ready_o, inp_weight_ready_o, inp_bias_ready_o, valid_o, busy_o} == 5'b0)
    else begin
      errors++;
      $display("** Error %s: expected %b, actual %b", test_name, 5'b0,
               {inp_ready_o, inp_weight_ready_o, inp_bias_ready_o, valid_o, busy_o});
    end

    for (int j = 0; j < NJobs; j++) begin
      run_job(j);
    end

    assert (sat_hi > 0 && sat_lo > 0) else begin
      errors++;
      $display("Error: saturation was not reached at both limits");
    end
    assert (relu_zero > 0 && relu_pos > 0) else begin
      errors++;
      $display("Error: ReLU did not see both negative and positive results");
    end

    $display("%0d rows checked, %0d errors", rows_checked, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/ita_dp_pkg.sv
design/ita_ctrl_pkg.sv
design/ita_cfg_regs.sv
design/ita_controller.sv
design/ita_weight_buffer.sv
design/ita_dotp_acc.sv
design/ita_requant_act.sv
design/ita_fifo.sv
design/ita.sv
sim/ita_tb.sv

// File: Bender.yml
package:
  name: ita

sources:
  - design/ita_dp_pkg.sv
  - design/ita_ctrl_pkg.sv
  - design/ita_cfg_regs.sv
  - design/ita_controller.sv
  - design/ita_weight_buffer.sv
  - design/ita_dotp_acc.sv
  - design/ita_requant_act.sv
  - design/ita_fifo.sv
  - design/ita.sv
  - target: simulation
    files:
      - sim/ita_tb.sv
